//--- Bender.yml
package:
  name: eth_tx

sources:
  - eth_pkg.sv
  - fifo_if.sv
  - frame_crc_append.sv
  - frame_fifo.sv
  - rgmii_send.sv
  - eth_tx_top.sv
  - target: test
    files:
      - tb_eth_tx.sv

//--- eth_pkg.sv
// shared framing constants, buffer word type and crc-32 step for the ethernet transmit path
`default_nettype none

package eth_pkg;

  // --------------------------------------------------
  // frame layout
  // --------------------------------------------------

  // seven 0x55 bytes then the 0xd5 delimiter, oldest byte in the msbs
  localparam logic [63:0] preamble_sfd = 64'h5555_5555_5555_55D5;
  localparam int          preamble_len = 8;

  // minimum idle time between frames in byte times
  localparam int          ifg_len      = 12;

  // frame check sequence bytes appended after the payload
  localparam int          fcs_len      = 4;

  // reflected ieee 802.3 polynomial
  localparam logic [31:0] crc32_poly   = 32'hEDB8_8320;

  // --------------------------------------------------
  // buffered byte
  // --------------------------------------------------
  typedef struct packed {
    logic [7:0] data;
    // marks the final fcs byte of a frame
    logic       last;
  } tx_byte_t;

  // advance the running crc by one byte, lsb first
  function automatic logic [31:0] crc32_next(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    int          i;
    c = crc ^ {24'h00_0000, data};
    for (i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ crc32_poly) : (c >> 1);
    end
    return c;
  endfunction

endpackage

`default_nettype wire

//--- eth_tx_top.sv
// gigabit ethernet transmit mac top, byte strobes in and rgmii nibble pairs out
`timescale 1ns/1ps
`default_nettype none

module eth_tx_top #(
  parameter int FIFO_DEPTH = 64
) (
  input  wire        clock,
  input  wire        arst_n,
  input  wire  [7:0] in_data,
  input  wire        in_valid,
  input  wire        in_last,
  output logic       in_full,
  output logic       tx_en,
  output logic [3:0] tx_d_rise,
  output logic [3:0] tx_d_fall
);

  // --------------------------------------------------
  // buffer bundles
  // --------------------------------------------------
  fifo_wr_if wr_bus ();
  fifo_rd_if rd_bus ();

  // payload in, fcs appended
  frame_crc_append u_crc_append (
    .clock    (clock),
    .arst_n   (arst_n),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_last  (in_last),
    .in_full  (in_full),
    .wr       (wr_bus.producer)
  );

  // holds a frame until its last byte arrives
  frame_fifo #(
    .DEPTH  (FIFO_DEPTH),
    .word_t (eth_pkg::tx_byte_t)
  ) u_frame_fifo (
    .clock  (clock),
    .arst_n (arst_n),
    .wr     (wr_bus.buffer),
    .rd     (rd_bus.buffer)
  );

  // preamble, nibbles and gap
  rgmii_send u_rgmii_send (
    .clock     (clock),
    .arst_n    (arst_n),
    .rd        (rd_bus.consumer),
    .tx_en     (tx_en),
    .tx_d_rise (tx_d_rise),
    .tx_d_fall (tx_d_fall)
  );

endmodule

`default_nettype wire

//--- fifo_if.sv
// write and read side bundles of the frame buffer, bound by the producer, buffer and consumer
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------
// write side
// --------------------------------------------------
interface fifo_wr_if;
  eth_pkg::tx_byte_t wr_data;
  // one byte stored per clock while high
  logic              wr_strobe;
  logic              full;
  // pulses together with the write of a last byte
  logic              frame_done;

  modport producer (output wr_data, output wr_strobe, output frame_done, input full);
  modport buffer   (input wr_data, input wr_strobe, input frame_done, output full);
endinterface

// --------------------------------------------------
// read side
// --------------------------------------------------
interface fifo_rd_if;
  // head word, valid without a clock of latency
  eth_pkg::tx_byte_t rd_data;
  // pops the head on the same clock
  logic              rd_strobe;
  // at least one whole frame stored
  logic              frame_ready;
  logic              empty;

  modport buffer   (output rd_data, output frame_ready, output empty, input rd_strobe);
  modport consumer (input rd_data, input frame_ready, input empty, output rd_strobe);
endinterface

`default_nettype wire

//--- filelist.f
eth_pkg.sv
fifo_if.sv
frame_crc_append.sv
frame_fifo.sv
rgmii_send.sv
eth_tx_top.sv
tb_eth_tx.sv

//--- frame_crc_append.sv
// producer that writes payload bytes into the frame buffer and follows each frame with its fcs
`timescale 1ns/1ps
`default_nettype none

module frame_crc_append (
  input  wire        clock,
  input  wire        arst_n,
  input  wire  [7:0] in_data,
  input  wire        in_valid,
  input  wire        in_last,
  output logic       in_full,
  fifo_wr_if.producer wr
);

  // --------------------------------------------------
  // fcs byte counter sizing
  // --------------------------------------------------
  localparam int                cnt_w    = $clog2(eth_pkg::fcs_len);
  localparam logic [cnt_w-1:0] last_idx = cnt_w'(eth_pkg::fcs_len - 1);

  logic              fcs_active;
  logic [cnt_w-1:0]  fcs_cnt;
  logic [31:0]       crc;
  logic [31:0]       crc_upd;
  logic [31:0]       fcs_sr;
  logic              pay_wr;
  logic              fcs_wr;
  logic              fcs_end;
  eth_pkg::tx_byte_t out_word;

  // payload goes straight through in its own cycle
  assign pay_wr  = in_valid && !fcs_active;
  // fcs bytes wait for room in the buffer
  assign fcs_wr  = fcs_active && !wr.full;
  assign fcs_end = fcs_wr && (fcs_cnt == last_idx);
  assign crc_upd = eth_pkg::crc32_next(crc, in_data);

  // --------------------------------------------------
  // buffer write mux
  // --------------------------------------------------
  always_comb begin
    if (fcs_active) begin
      out_word.data = fcs_sr[7:0];
      out_word.last = (fcs_cnt == last_idx);
    end else begin
      out_word.data = in_data;
      out_word.last = 1'b0;
    end
  end

  assign wr.wr_data    = out_word;
  assign wr.wr_strobe  = pay_wr || fcs_wr;
  assign wr.frame_done = fcs_end;

  // source holds off during the fcs tail and on a full buffer
  assign in_full = fcs_active || wr.full;

  // --------------------------------------------------
  // crc and fcs sequencing
  // --------------------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      fcs_active <= 1'b0;
      fcs_cnt    <= '0;
      crc        <= '1;
    end else begin
      if (pay_wr) begin
        if (in_last) begin
          // preset for the next frame right away
          crc        <= '1;
          fcs_active <= 1'b1;
          fcs_cnt    <= '0;
        end else begin
          crc <= crc_upd;
        end
      end
      if (fcs_wr) begin
        fcs_cnt <= fcs_cnt + 1'b1;
        if (fcs_end) begin
          fcs_active <= 1'b0;
        end
      end
    end
  end

  // inverted crc, sent lsb byte first
  always_ff @(posedge clock) begin
    if (pay_wr && in_last) begin
      fcs_sr <= ~crc_upd;
    end else if (fcs_wr) begin
      fcs_sr <= {8'h00, fcs_sr[31:8]};
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // source and fcs tail both respect the buffer level
  a_no_write_when_full : assert property (
    @(posedge clock) disable iff (!arst_n)
    wr.wr_strobe |-> !wr.full
  ) else $error("frame_crc_append: byte written while buffer full");

endmodule

`default_nettype wire

//--- frame_fifo.sv
// store-and-forward frame buffer with a combinational head, announcing whole frames only
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
  parameter int  DEPTH  = 64,
  parameter type word_t = eth_pkg::tx_byte_t
) (
  input  wire       clock,
  input  wire       arst_n,
  fifo_wr_if.buffer wr,
  fifo_rd_if.buffer rd
);

  // --------------------------------------------------
  // sizing
  // --------------------------------------------------
  localparam int               ptr_w    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int               cnt_w    = $clog2(DEPTH + 1);
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(DEPTH - 1);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(DEPTH);

  word_t            mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  // frames fully stored and not yet fully read
  logic [cnt_w-1:0] frame_count;
  logic             do_wr;
  logic             do_rd;
  logic             frame_out;

  assign do_wr     = wr.wr_strobe;
  assign do_rd     = rd.rd_strobe;
  // last byte of a frame leaving the buffer
  assign frame_out = do_rd && rd.rd_data.last;

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr.wr_data;
    end
  end

  // old word still reads out when a write hits the head slot
  assign rd.rd_data = mem[rd_ptr];

  // --------------------------------------------------
  // pointers and levels
  // --------------------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign wr.full  = (count == cnt_full);
  assign rd.empty = (count == '0);

  // --------------------------------------------------
  // frame bookkeeping
  // --------------------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      frame_count <= '0;
    end else begin
      case ({wr.frame_done, frame_out})
        2'b10:   frame_count <= frame_count + 1'b1;
        2'b01:   frame_count <= frame_count - 1'b1;
        default: frame_count <= frame_count;
      endcase
    end
  end

  // rises one clock after the last byte is written
  assign rd.frame_ready = (frame_count != '0);

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // a write at full is only safe when the head leaves the same clock
  a_no_overflow : assert property (
    @(posedge clock) disable iff (!arst_n)
    (do_wr && wr.full) |-> do_rd
  ) else $error("frame_fifo: write into full buffer without a read");

  a_no_underflow : assert property (
    @(posedge clock) disable iff (!arst_n)
    do_rd |-> !rd.empty
  ) else $error("frame_fifo: read from empty buffer");

endmodule

`default_nettype wire

//--- rgmii_send.sv
// rgmii transmit sequencer that prepends the preamble, drives nibble pairs and holds the ifg
`timescale 1ns/1ps
`default_nettype none

module rgmii_send (
  input  wire         clock,
  input  wire         arst_n,
  fifo_rd_if.consumer rd,
  output logic        tx_en,
  output logic [3:0]  tx_d_rise,
  output logic [3:0]  tx_d_fall
);

  // --------------------------------------------------
  // shift register and counter loads
  // --------------------------------------------------
  localparam int         sr_hi      = 8 * eth_pkg::preamble_len - 1;
  // flush covers the bytes still in the shift register
  localparam logic [3:0] flush_load = 4'(eth_pkg::preamble_len - 1);
  localparam logic [3:0] gap_load   = 4'(eth_pkg::ifg_len - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_gap
  } state_t;

  state_t            state;
  // buffer still supplying bytes of this frame
  logic              reading;
  // flush or gap countdown
  logic [3:0]        bytes_left;
  logic [sr_hi:0]    shift_reg;
  logic              start;
  logic              sending;
  logic              last_pop;
  logic [7:0]        in_byte;
  eth_pkg::tx_byte_t head;

  assign head     = rd.rd_data;
  // only a whole buffered frame may start, the wire cannot pause
  assign start    = (state == st_idle) && rd.frame_ready;
  assign rd.rd_strobe = start || ((state == st_send) && reading);
  assign last_pop = rd.rd_strobe && head.last;
  assign sending  = start || (state == st_send);
  // zeros fill in behind the frame during the flush
  assign in_byte  = rd.rd_strobe ? head.data : 8'h00;

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      reading    <= 1'b0;
      bytes_left <= '0;
    end else begin
      case (state)
        st_idle: begin
          // first byte read here
          if (start) begin
            state      <= st_send;
            reading    <= !last_pop;
            bytes_left <= flush_load;
          end
        end
        st_send: begin
          if (reading) begin
            bytes_left <= flush_load;
            if (last_pop) begin
              reading <= 1'b0;
            end
          end else if (bytes_left != '0) begin
            // draining the shift register
            bytes_left <= bytes_left - 1'b1;
          end else begin
            bytes_left <= gap_load;
            state      <= st_gap;
          end
        end
        st_gap: begin
          if (bytes_left != '0) begin
            bytes_left <= bytes_left - 1'b1;
          end else begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // byte pipeline
  // --------------------------------------------------

  // reloads the preamble whenever the line is quiet
  always_ff @(posedge clock) begin
    if (sending) begin
      shift_reg <= {shift_reg[sr_hi-8:0], in_byte};
    end else begin
      shift_reg <= eth_pkg::preamble_sfd;
    end
  end

  // oldest byte out, low nibble on the rising edge slot
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      tx_en     <= 1'b0;
      tx_d_rise <= 4'h0;
      tx_d_fall <= 4'h0;
    end else begin
      tx_en     <= sending;
      tx_d_rise <= sending ? shift_reg[sr_hi-4 -: 4] : 4'h0;
      tx_d_fall <= sending ? shift_reg[sr_hi -: 4] : 4'h0;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // frame_ready promised the rest of the frame is already stored
  a_frame_complete : assert property (
    @(posedge clock) disable iff (!arst_n)
    ((state == st_send) && reading) |-> !rd.empty
  ) else $error("rgmii_send: buffer ran empty in the middle of a frame");

endmodule

`default_nettype wire

//--- tb_eth_tx.sv
// self-checking testbench for the ethernet transmit mac, frames and fcs come from a data file
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx;

  // --------------------------------------------------
  // setup
  // --------------------------------------------------
  localparam int fifo_depth  = 64;
  localparam int mem_size    = 1024;
  localparam int max_frames  = 32;
  // first pass with random idle, second pass back to back
  localparam int passes      = 2;
  localparam int stall_limit = 1000;
  localparam int done_limit  = 20000;

  logic       clock;
  logic       arst_n;
  logic [7:0] in_data;
  logic       in_valid;
  logic       in_last;
  wire        in_full;
  wire        tx_en;
  wire  [3:0] tx_d_rise;
  wire  [3:0] tx_d_fall;

  // raw file image and frame index
  logic [7:0] frame_mem [mem_size];
  int         frame_start [max_frames];
  int         frame_len [max_frames];
  int         num_frames = 0;
  int         seed = 7;
  int         errors = 0;
  int         checks = 0;
  bit         driver_stuck = 1'b0;
  bit         b2b_pass = 1'b0;
  bit         full_seen = 1'b0;

  // monitor state
  logic [7:0] burst_q [$];
  bit         in_burst = 1'b0;
  int         gap_cycles = 0;
  int         frames_seen = 0;
  // consecutive samples with in_full high
  int         full_run = 0;

  eth_tx_top #(
    .FIFO_DEPTH (fifo_depth)
  ) UUT (
    .clock     (clock),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_full   (in_full),
    .tx_en     (tx_en),
    .tx_d_rise (tx_d_rise),
    .tx_d_fall (tx_d_fall)
  );

  // 4 ns period
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  // --------------------------------------------------
  // data file
  // --------------------------------------------------

  // each record is a length byte, the payload, then 4 fcs bytes, ended by a zero length
  task automatic load_frames();
    int ptr;
    $readmemh("tb_frames_input.txt", frame_mem);
    ptr = 0;
    while (ptr < mem_size && num_frames < max_frames &&
           !$isunknown(frame_mem[ptr]) && frame_mem[ptr] != 8'h00) begin
      frame_len[num_frames]   = frame_mem[ptr];
      frame_start[num_frames] = ptr + 1;
      if (frame_len[num_frames] + eth_pkg::fcs_len > fifo_depth) begin
        $display("frame %0d is longer than the buffer can hold", num_frames);
        errors++;
      end
      ptr = ptr + 1 + frame_len[num_frames] + eth_pkg::fcs_len;
      num_frames++;
    end
    if (num_frames == 0) begin
      $display("no frames were read from the data file");
      errors++;
    end
  endtask

  // --------------------------------------------------
  // driver
  // --------------------------------------------------

  // entered and left 1 ns after a rising edge
  task automatic drive_byte(input logic [7:0] data, input logic last);
    int waited;
    waited = 0;
    while (in_full && waited < stall_limit) begin
      in_valid = 1'b0;
      @(posedge clock);
      #1;
      waited++;
    end
    if (in_full) begin
      $display("timeout: in_full stayed high for %0d cycles, driver stopped", stall_limit);
      errors++;
      driver_stuck = 1'b1;
    end else begin
      in_data  = data;
      in_valid = 1'b1;
      in_last  = last;
      @(posedge clock);
      #1;
      in_valid = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  task automatic send_frame(input int idx, input bit gaps);
    int i;
    int idle;
    for (i = 0; i < frame_len[idx] && !driver_stuck; i++) begin
      if (gaps) begin
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) begin
          @(posedge clock);
          #1;
        end
      end
      drive_byte(frame_mem[frame_start[idx] + i], i == frame_len[idx] - 1);
    end
  endtask

  // --------------------------------------------------
  // monitor
  // --------------------------------------------------

  // burst layout is preamble, payload, fcs
  task automatic check_burst(input int idx);
    int n;
    int base;
    int i;
    logic [7:0] pre;
    n    = frame_len[idx];
    base = frame_start[idx];
    check_value($sformatf("burst_len frame %0d", idx),
                eth_pkg::preamble_len + n + eth_pkg::fcs_len, burst_q.size());
    if (burst_q.size() == eth_pkg::preamble_len + n + eth_pkg::fcs_len) begin
      for (i = 0; i < eth_pkg::preamble_len; i++) begin
        // sfd closes the preamble
        pre = (i == eth_pkg::preamble_len - 1) ? 8'hD5 : 8'h55;
        check_value($sformatf("preamble frame %0d byte %0d", idx, i), pre, burst_q[i]);
      end
      for (i = 0; i < n; i++) begin
        check_value($sformatf("payload frame %0d byte %0d", idx, i),
                    frame_mem[base + i], burst_q[eth_pkg::preamble_len + i]);
      end
      for (i = 0; i < eth_pkg::fcs_len; i++) begin
        check_value($sformatf("fcs frame %0d byte %0d", idx, i),
                    frame_mem[base + n + i], burst_q[eth_pkg::preamble_len + n + i]);
      end
    end
  endtask

  // outputs settle at the rising edge, sampled on the falling one
  always @(negedge clock) begin
    if (arst_n) begin
      if (in_full) begin
        full_run++;
      end else begin
        full_run = 0;
      end
      // a stall longer than the fcs tail means the buffer itself is full
      if (b2b_pass && full_run > eth_pkg::fcs_len) begin
        full_seen = 1'b1;
      end
      if (tx_en) begin
        if (!in_burst && frames_seen > 0) begin
          // a short gap shows as its actual length
          check_value("ifg", eth_pkg::ifg_len,
                      (gap_cycles < eth_pkg::ifg_len) ? gap_cycles : eth_pkg::ifg_len);
        end
        in_burst = 1'b1;
        burst_q.push_back({tx_d_fall, tx_d_rise});
      end else if (in_burst) begin
        if (num_frames > 0) begin
          check_burst(frames_seen % num_frames);
        end
        burst_q.delete();
        frames_seen++;
        in_burst   = 1'b0;
        gap_cycles = 1;
      end else begin
        gap_cycles++;
      end
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int p;
    int f;
    int cycles;
    arst_n   = 1'b0;
    in_data  = 8'h00;
    in_valid = 1'b0;
    in_last  = 1'b0;
    load_frames();

    // two rising edges in reset, outputs checked in between
    @(posedge clock);
    @(negedge clock);
    check_value("reset tx_en", 0, tx_en);
    check_value("reset in_full", 0, in_full);
    @(posedge clock);
    #1;
    arst_n = 1'b1;
    @(negedge clock);
    check_value("after reset tx_en", 0, tx_en);
    check_value("after reset in_full", 0, in_full);
    check_value("after reset nibbles", 0, {tx_d_fall, tx_d_rise});
    @(posedge clock);
    #1;

    fork
      begin
        for (p = 0; p < passes; p++) begin
          b2b_pass = (p == passes - 1);
          for (f = 0; f < num_frames && !driver_stuck; f++) begin
            send_frame(f, !b2b_pass);
          end
        end
      end
      begin
        cycles = 0;
        while (frames_seen < passes * num_frames && cycles < done_limit) begin
          @(posedge clock);
          cycles++;
        end
      end
    join

    if (frames_seen < passes * num_frames) begin
      $display("timeout: only %0d of %0d frames came out on the rgmii side",
               frames_seen, passes * num_frames);
      errors++;
    end
    check_value("backpressure in_full seen", 1, full_seen);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_frames_input.txt
// columns: payload length, payload bytes, expected fcs bytes lsb first, all hex
// a length of 00 ends the frame list
// "a"
01 61 43 BE B7 E8
// "abc"
03 61 62 63 C2 41 24 35
// "123456789"
09 31 32 33 34 35 36 37 38 39 26 39 F4 CB
// "hello world"
0B 68 65 6C 6C 6F 20 77 6F 72 6C 64 85 11 4A 0D
// "message digest"
0E 6D 65 73 73 61 67 65 20 64 69 67 65 73 74 7F 9D 15 20
// lower case alphabet
1A 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F 70 71 72 73 74 75 76 77 78 79 7A BD 50 27 4C
// end of list
00
